// ==== include/divsqrt_macros.svh ====
// ---------------------------------------------------------------------
// Divide/sqrt wrapper global defines
// Operand and tag widths, default depths of the elastic pipelines
// ---------------------------------------------------------------------
`ifndef DIVSQRT_MACROS_SVH
`define DIVSQRT_MACROS_SVH

// Widest supported format, FP64
`define DIVSQRT_WIDTH 64

// Transaction tag width
`define DIVSQRT_TAG_W 8

// Register stages in front of the controller
`define DIVSQRT_INP_REGS 1

// Register stages behind the controller
`define DIVSQRT_OUT_REGS 1

`endif

// ==== rtl/divsqrt_ctrl.sv ====
// ---------------------------------------------------------------------
// Divide/sqrt control FSM
// Starts the engine, commits or holds results, captures the tag
// ---------------------------------------------------------------------
module divsqrt_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  // From input pipeline
  input  logic                   in_valid_i,
  input  divsqrt_ctrl_pkg::tag_t in_tag_i,
  output logic                   in_ready_o,
  // Engine side
  input  logic                   unit_busy_i,
  input  logic                   unit_done_i,
  output logic                   start_o,
  // To output pipeline
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output divsqrt_ctrl_pkg::tag_t out_tag_o,
  output logic                   busy_o
);

  import divsqrt_ctrl_pkg::*;

  fsm_state_e state_q, state_d;
  tag_t       tag_q;
  logic       unit_ready;

  assign unit_ready = ~unit_busy_i;
  assign start_o    = in_valid_i & in_ready_o & ~flush_i;  // Accepted item

  always_comb begin
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;

    unique case (state_q)
      IDLE: begin
        in_ready_o = unit_ready;
        if (in_valid_i && unit_ready) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        busy_o = 1'b1;  // Operation in flight
        if (unit_done_i) begin
          out_valid_o = 1'b1;  // Try to commit
          if (out_ready_i) begin
            state_d    = IDLE;
            in_ready_o = unit_ready;  // Take next while committing
            if (in_valid_i && unit_ready) begin
              state_d = BUSY;
            end
          end else begin
            state_d = HOLD;  // Downstream stalls
          end
        end
      end
      // Engine keeps its result until the next start
      HOLD: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d = IDLE;
          if (in_valid_i && unit_ready) begin
            in_ready_o = 1'b1;
            state_d    = BUSY;
          end
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush overrides everything
    if (flush_i) begin
      busy_o      = 1'b0;
      out_valid_o = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Tag follows the operation from its start
  always_ff @(posedge clk_i) begin
    if (start_o) begin
      tag_q <= in_tag_i;
    end
  end

  assign out_tag_o = tag_q;

endmodule

// ==== rtl/divsqrt_ctrl_pkg.sv ====
// ---------------------------------------------------------------------
// Divide/sqrt control types
// Operations, FSM states, status flags and transaction tags
// ---------------------------------------------------------------------
`include "divsqrt_macros.svh"

package divsqrt_ctrl_pkg;

  // Anything but DIV runs a square root
  typedef enum logic {
    DIV  = 1'b0,
    SQRT = 1'b1
  } operation_e;

  // Flags, divide-by-zero in the upper bit
  typedef logic [1:0] status_t;

  localparam int unsigned STATUS_DZ = 1;  // Divide by zero
  localparam int unsigned STATUS_NX = 0;  // Nonzero remainder

  typedef logic [`DIVSQRT_TAG_W-1:0] tag_t;

  // Controller states
  typedef enum logic [1:0] {IDLE, BUSY, HOLD} fsm_state_e;

endpackage

// ==== rtl/divsqrt_fmt_pkg.sv ====
// ---------------------------------------------------------------------
// Divide/sqrt format types
// Destination formats, engine format codes and operand words
// ---------------------------------------------------------------------
`include "divsqrt_macros.svh"

package divsqrt_fmt_pkg;

  // Destination format, fpnew encoding order
  typedef enum logic [2:0] {
    FP32 = 3'd0,
    FP64 = 3'd1,
    FP16 = 3'd2
  } fp_format_e;

  // Engine format code
  typedef logic [1:0] dsu_fmt_t;

  localparam dsu_fmt_t DSU_FMT_H = 2'b00;  // 16-bit
  localparam dsu_fmt_t DSU_FMT_S = 2'b01;  // 32-bit
  localparam dsu_fmt_t DSU_FMT_D = 2'b10;  // 64-bit

  // Operand/result word at max width
  typedef logic [`DIVSQRT_WIDTH-1:0] fp_word_t;

endpackage

// ==== rtl/divsqrt_iter_unit.sv ====
// ---------------------------------------------------------------------
// Radix-2 iterative divide/sqrt engine
// Integer quotient or root at 16/32/64-bit width, NaN-boxed result
// One result bit per cycle, plus a final cycle for result and flags
// ---------------------------------------------------------------------
`include "divsqrt_macros.svh"

module divsqrt_iter_unit (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  input  logic                         start_i,  // Latch operands, begin
  input  divsqrt_ctrl_pkg::operation_e op_i,
  input  divsqrt_fmt_pkg::fp_format_e  fmt_i,
  input  divsqrt_fmt_pkg::fp_word_t    opa_i,    // Dividend or radicand
  input  divsqrt_fmt_pkg::fp_word_t    opb_i,    // Divisor
  output logic                         busy_o,
  output logic                         done_o,   // Level, cleared by start
  output divsqrt_fmt_pkg::fp_word_t    result_o,
  output divsqrt_ctrl_pkg::status_t    status_o
);

  import divsqrt_fmt_pkg::*;
  import divsqrt_ctrl_pkg::*;

  localparam int unsigned W    = `DIVSQRT_WIDTH;
  localparam int unsigned CntW = $clog2(W) + 1;

  // Width in bits of an engine format
  function automatic logic [CntW-1:0] fmt_bits(dsu_fmt_t fmt);
    logic [CntW-1:0] bits;
    unique case (fmt)
      DSU_FMT_H: bits = CntW'(16);
      DSU_FMT_S: bits = CntW'(32);
      DSU_FMT_D: bits = CntW'(64);
      default:   bits = CntW'(W);
    endcase
    return bits;
  endfunction

  // -------------------------------------------------------------------
  // Format translation and operand extraction
  // -------------------------------------------------------------------
  dsu_fmt_t        dsu_fmt;
  logic [CntW-1:0] start_bits;
  logic [CntW-1:0] start_iters;

  always_comb begin
    unique case (fmt_i)
      FP64:    dsu_fmt = DSU_FMT_D;
      FP32:    dsu_fmt = DSU_FMT_S;
      FP16:    dsu_fmt = DSU_FMT_H;
      default: dsu_fmt = DSU_FMT_D;  // Max width
    endcase
  end

  assign start_bits  = fmt_bits(dsu_fmt);
  // Sqrt yields one root bit per two operand bits
  assign start_iters = (op_i == DIV) ? start_bits : (start_bits >> 1);

  // -------------------------------------------------------------------
  // Iteration datapath
  // -------------------------------------------------------------------
  logic            busy_q;
  logic            done_q;
  logic            is_div_q;
  dsu_fmt_t        fmt_q;
  logic [CntW-1:0] cnt_q;     // Iterations left
  logic [W-1:0]    src_q;     // Operand a, MSB aligned, shifts out
  logic [W-1:0]    dvs_q;     // Divisor, zero-extended
  logic [W-1:0]    quo_q;     // Quotient or root bits
  logic [W:0]      rem_q;     // Partial remainder
  fp_word_t        result_q;
  status_t         status_q;

  logic [W:0]   partial;
  logic [W:0]   trial;
  logic [W:0]   diff;
  logic         ge;
  logic         div_zero;
  logic [W-1:0] box_mask;

  always_comb begin
    if (is_div_q) begin
      partial = {rem_q[W-1:0], src_q[W-1]};    // Bring down one bit
      trial   = {1'b0, dvs_q};
    end else begin
      partial = {rem_q[W-2:0], src_q[W-1 -: 2]};  // Bring down a bit pair
      trial   = {quo_q[W-2:0], 2'b01};         // 4*root + 1
    end
  end

  assign ge       = (partial >= trial);  // Restoring step succeeds
  assign diff     = partial - trial;
  assign div_zero = is_div_q & (dvs_q == '0);
  assign box_mask = {W{1'b1}} << fmt_bits(fmt_q);  // Ones above width

  // Control state
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= start_iters;
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        busy_q <= 1'b0;  // Final cycle done
        done_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Operand latch, iterations, result and flags
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      is_div_q <= (op_i == DIV);
      fmt_q    <= dsu_fmt;
      src_q    <= opa_i << (CntW'(W) - start_bits);  // Upper bits drop out
      dvs_q    <= opb_i & ~({W{1'b1}} << start_bits);
      quo_q    <= '0;
      rem_q    <= '0;
    end else if (busy_q && cnt_q != '0) begin
      src_q <= is_div_q ? (src_q << 1) : (src_q << 2);
      rem_q <= ge ? diff : partial;
      quo_q <= {quo_q[W-2:0], ge};
    end else if (busy_q) begin
      // Zero divisor gives all ones within the width
      result_q            <= quo_q | box_mask;
      status_q[STATUS_DZ] <= div_zero;
      status_q[STATUS_NX] <= (rem_q != '0) & ~div_zero;
    end
  end

  assign busy_o   = busy_q;
  assign done_o   = done_q;
  assign result_o = result_q;  // Held until next start
  assign status_o = status_q;

endmodule

// ==== rtl/divsqrt_pipe_regs.sv ====
// ---------------------------------------------------------------------
// Elastic register pipeline
// Chain of valid/ready stages with a flush, bubbles get popped
// ---------------------------------------------------------------------
module divsqrt_pipe_regs #(
  parameter int unsigned NumRegs   = 1,
  parameter int unsigned DataWidth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  // Upstream side
  input  logic                 valid_i,
  output logic                 ready_o,
  input  logic [DataWidth-1:0] data_i,
  // Downstream side
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] data_o
);

  if (NumRegs == 0) begin : gen_bypass
    assign valid_o = valid_i;  // Pure pass-through
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_stages
    logic [NumRegs-1:0]   valid_q;
    logic [DataWidth-1:0] data_q [NumRegs];
    logic [NumRegs-1:0]   load;  // Stage may take a new item

    // Stage advances if the next one is ready or only holds a bubble
    always_comb begin
      load[NumRegs-1] = ready_i | ~valid_q[NumRegs-1];
      for (int i = int'(NumRegs) - 2; i >= 0; i--) begin
        load[i] = load[i+1] | ~valid_q[i];
      end
    end

    // Valids, flush wins over any move
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q <= '0;
      end else if (flush_i) begin
        valid_q <= '0;
      end else begin
        if (load[0]) begin
          valid_q[0] <= valid_i;
        end
        for (int i = 1; i < NumRegs; i++) begin
          if (load[i]) begin
            valid_q[i] <= valid_q[i-1];
          end
        end
      end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clk_i) begin
      if (load[0] && valid_i) begin
        data_q[0] <= data_i;
      end
      for (int i = 1; i < NumRegs; i++) begin
        if (load[i] && valid_q[i-1]) begin
          data_q[i] <= data_q[i-1];
        end
      end
    end

    assign ready_o = load[0];
    assign valid_o = valid_q[NumRegs-1];  // Last stage faces downstream
    assign data_o  = data_q[NumRegs-1];
  end

endmodule

// ==== rtl/divsqrt_top.sv ====
// ---------------------------------------------------------------------
// Multi-format divide/sqrt wrapper
// Input pipeline, control FSM, iterative engine, output pipeline
// ---------------------------------------------------------------------
`include "divsqrt_macros.svh"

module divsqrt_top #(
  parameter int unsigned NumInpRegs = `DIVSQRT_INP_REGS,
  parameter int unsigned NumOutRegs = `DIVSQRT_OUT_REGS
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            flush_i,
  // Input handshake and payload
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  input  divsqrt_fmt_pkg::fp_word_t [1:0] operands_i,
  input  divsqrt_ctrl_pkg::operation_e    op_i,
  input  divsqrt_fmt_pkg::fp_format_e     dst_fmt_i,
  input  divsqrt_ctrl_pkg::tag_t          tag_i,
  // Output handshake and payload
  output logic                            out_valid_o,
  input  logic                            out_ready_i,
  output divsqrt_fmt_pkg::fp_word_t       result_o,
  output divsqrt_ctrl_pkg::status_t       status_o,
  output divsqrt_ctrl_pkg::tag_t          tag_o,
  output logic                            busy_o
);

  import divsqrt_fmt_pkg::*;
  import divsqrt_ctrl_pkg::*;

  localparam int unsigned WordW = $bits(fp_word_t);
  localparam int unsigned OpW   = $bits(operation_e);
  localparam int unsigned FmtW  = $bits(fp_format_e);
  localparam int unsigned TagW  = $bits(tag_t);
  localparam int unsigned StatW = $bits(status_t);
  localparam int unsigned InpW  = 2 * WordW + OpW + FmtW + TagW;
  localparam int unsigned OutW  = WordW + StatW + TagW;

  // -------------------------------------------------------------------
  // Input pipeline
  // -------------------------------------------------------------------
  logic              inp_valid_q;
  logic              inp_ready;       // From controller accept
  logic              inp_pipe_ready;  // Pipe entry can take an item
  logic [InpW-1:0]   inp_data;
  logic [InpW-1:0]   inp_data_q;
  fp_word_t [1:0]    operands_q;
  operation_e        op_q;
  fp_format_e        fmt_q;
  tag_t              tag_q;

  assign inp_data = {operands_i, op_i, dst_fmt_i, tag_i};

  divsqrt_pipe_regs #(
    .NumRegs   ( NumInpRegs ),
    .DataWidth ( InpW       )
  ) i_inp_pipe (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .flush_i ( flush_i        ),
    .valid_i ( in_valid_i     ),
    .ready_o ( inp_pipe_ready ),
    .data_i  ( inp_data       ),
    .valid_o ( inp_valid_q    ),
    .ready_i ( inp_ready      ),
    .data_o  ( inp_data_q     )
  );

  // Nothing is taken while reset holds
  assign in_ready_o = inp_pipe_ready & rst_n_i;

  // Unpack the far end of the pipe
  assign operands_q = inp_data_q[InpW-1 -: 2*WordW];
  assign op_q       = operation_e'(inp_data_q[FmtW+TagW +: OpW]);
  assign fmt_q      = fp_format_e'(inp_data_q[TagW +: FmtW]);
  assign tag_q      = inp_data_q[TagW-1:0];

  // -------------------------------------------------------------------
  // Controller and engine
  // -------------------------------------------------------------------
  logic     unit_start;
  logic     unit_busy;
  logic     unit_done;
  fp_word_t unit_result;
  status_t  unit_status;
  logic     ctrl_out_valid;
  logic     ctrl_out_ready;
  tag_t     ctrl_out_tag;
  logic     ctrl_busy;

  divsqrt_ctrl i_ctrl (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .flush_i     ( flush_i        ),
    .in_valid_i  ( inp_valid_q    ),
    .in_tag_i    ( tag_q          ),
    .in_ready_o  ( inp_ready      ),
    .unit_busy_i ( unit_busy      ),
    .unit_done_i ( unit_done      ),
    .start_o     ( unit_start     ),
    .out_valid_o ( ctrl_out_valid ),
    .out_ready_i ( ctrl_out_ready ),
    .out_tag_o   ( ctrl_out_tag   ),
    .busy_o      ( ctrl_busy      )
  );

  divsqrt_iter_unit i_unit (
    .clk_i    ( clk_i         ),
    .rst_n_i  ( rst_n_i       ),
    .flush_i  ( flush_i       ),
    .start_i  ( unit_start    ),
    .op_i     ( op_q          ),
    .fmt_i    ( fmt_q         ),
    .opa_i    ( operands_q[0] ),
    .opb_i    ( operands_q[1] ),
    .busy_o   ( unit_busy     ),
    .done_o   ( unit_done     ),
    .result_o ( unit_result   ),
    .status_o ( unit_status   )
  );

  // -------------------------------------------------------------------
  // Output pipeline
  // -------------------------------------------------------------------
  logic [OutW-1:0] out_data_q;

  divsqrt_pipe_regs #(
    .NumRegs   ( NumOutRegs ),
    .DataWidth ( OutW       )
  ) i_out_pipe (
    .clk_i   ( clk_i                                    ),
    .rst_n_i ( rst_n_i                                  ),
    .flush_i ( flush_i                                  ),
    .valid_i ( ctrl_out_valid                           ),
    .ready_o ( ctrl_out_ready                           ),
    .data_i  ( {unit_result, unit_status, ctrl_out_tag} ),
    .valid_o ( out_valid_o                              ),
    .ready_i ( out_ready_i                              ),
    .data_o  ( out_data_q                               )
  );

  assign result_o = out_data_q[OutW-1 -: WordW];
  assign status_o = out_data_q[TagW +: StatW];
  assign tag_o    = out_data_q[TagW-1:0];

  // Anything in flight keeps the unit busy
  assign busy_o = inp_valid_q | ctrl_busy | out_valid_o;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the divide/sqrt wrapper testbench with Verilator

LOG=sim.log
OBJ=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_divsqrt_top -Mdir "$OBJ" -o tb_divsqrt_top -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_divsqrt_top" +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// ==== src.f ====
+incdir+include
rtl/divsqrt_fmt_pkg.sv
rtl/divsqrt_ctrl_pkg.sv
rtl/divsqrt_pipe_regs.sv
rtl/divsqrt_iter_unit.sv
rtl/divsqrt_ctrl.sv
rtl/divsqrt_top.sv
testbench/divsqrt_chk.sv
testbench/tb_divsqrt_top.sv

// ==== testbench/divsqrt_chk.sv ====
// ---------------------------------------------------------------------
// Protocol checker for the divide/sqrt wrapper
// Output stability under back-pressure, busy coverage, flush effect
// ---------------------------------------------------------------------
module divsqrt_chk (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      flush_i,
  input logic                      out_valid_o,
  input logic                      out_ready_i,
  input divsqrt_fmt_pkg::fp_word_t result_o,
  input divsqrt_ctrl_pkg::status_t status_o,
  input divsqrt_ctrl_pkg::tag_t    tag_o,
  input logic                      busy_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;  // Assertion failures so far

  // Stalled output keeps its valid
  property p_hold_valid;
    @(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i && !flush_i |=> out_valid_o;
  endproperty

  // Stalled output keeps its payload
  property p_hold_data;
    @(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i && !flush_i |=>
        $stable(result_o) && $stable(status_o) && $stable(tag_o);
  endproperty

  // A result only shows after the unit was already busy with it
  property p_valid_busy;
    @(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o |-> busy_o && $past(busy_o);
  endproperty

  // Flush empties everything within one cycle
  property p_flush_empty;
    @(posedge clk_i) disable iff (!rst_n_i)
      flush_i |=> !out_valid_o && !busy_o;
  endproperty

  a_hold_valid: assert property (p_hold_valid) else begin
    $error("out_valid_o dropped before the result was accepted");
    fail_count++;
  end
  a_hold_data: assert property (p_hold_data) else begin
    $error("Output payload changed while stalled");
    fail_count++;
  end
  a_valid_busy: assert property (p_valid_busy) else begin
    $error("out_valid_o high without busy_o high now and one cycle before");
    fail_count++;
  end
  a_flush_empty: assert property (p_flush_empty) else begin
    $error("Design not empty one cycle after flush");
    fail_count++;
  end

endmodule

// ==== testbench/tb_divsqrt_top.sv ====
// ---------------------------------------------------------------------
// Testbench for the divide/sqrt wrapper
// Directed and random items against a queue model, random output stalls
// ---------------------------------------------------------------------
module tb_divsqrt_top;
  timeunit 1ns;
  timeprecision 1ps;

  import divsqrt_fmt_pkg::*;
  import divsqrt_ctrl_pkg::*;

  logic           clk_i;
  logic           rst_n_i;
  logic           flush_i;
  logic           in_valid_i;
  logic           in_ready_o;
  fp_word_t [1:0] operands_i;   // [0] dividend/radicand, [1] divisor
  operation_e     op_i;
  fp_format_e     dst_fmt_i;
  tag_t           tag_i;
  logic           out_valid_o;
  logic           out_ready_i;
  fp_word_t       result_o;
  status_t        status_o;
  tag_t           tag_o;
  logic           busy_o;

  integer seed = 32'had18;
  int     checks = 0;
  int     value_errs = 0;
  int     other_errs = 0;
  tag_t   next_tag = '0;
  logic   in_taken = 1'b0;       // Offered item taken this cycle

  // Items still to be offered
  fp_word_t   stim_a[$];
  fp_word_t   stim_b[$];
  operation_e stim_op[$];
  fp_format_e stim_fmt[$];
  // Expected responses in issue order
  fp_word_t   exp_res[$];
  status_t    exp_st[$];
  tag_t       exp_tag[$];

  divsqrt_top u_dut (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .operands_i  ( operands_i  ),
    .op_i        ( op_i        ),
    .dst_fmt_i   ( dst_fmt_i   ),
    .tag_i       ( tag_i       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .busy_o      ( busy_o      )
  );

  bind divsqrt_top divsqrt_chk u_chk (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .busy_o      ( busy_o      )
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;  // 8 ns period

  // ---------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------
  function automatic int fmt_width(input fp_format_e fmt);
    case (fmt)
      FP16:    return 16;
      FP32:    return 32;
      default: return 64;
    endcase
  endfunction

  function automatic fp_word_t width_mask(input fp_format_e fmt);
    case (fmt)
      FP16:    return 64'h0000_0000_0000_ffff;
      FP32:    return 64'h0000_0000_ffff_ffff;
      default: return '1;
    endcase
  endfunction

  // Largest root whose square fits, built greedily from the top bit
  function automatic fp_word_t int_sqrt(input fp_word_t v);
    fp_word_t root;
    fp_word_t cand;
    root = '0;
    for (int i = 31; i >= 0; i--) begin
      cand = root | (64'd1 << i);
      if (cand * cand <= v) root = cand;
    end
    return root;
  endfunction

  function automatic fp_word_t model_result(input operation_e op, input fp_format_e fmt,
                                            input fp_word_t a, input fp_word_t b,
                                            output status_t st);
    fp_word_t mask;
    fp_word_t am;
    fp_word_t bm;
    fp_word_t q;
    mask = width_mask(fmt);
    am   = a & mask;
    bm   = b & mask;
    st   = '0;
    if (op == DIV) begin
      if (bm == '0) begin
        q     = mask;             // All ones within the width
        st[1] = 1'b1;             // Divide by zero
      end else begin
        q     = am / bm;
        st[0] = (am % bm) != '0;  // Inexact
      end
    end else begin
      q     = int_sqrt(am);
      st[0] = (q * q) != am;
    end
    return q | ~mask;             // NaN-boxing
  endfunction

  // ---------------------------------------------------------------------
  // Compare tasks
  // ---------------------------------------------------------------------
  task automatic check_result(input string name, input fp_word_t got, input fp_word_t exp);
    checks++;
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    checks++;
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    checks++;
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  function automatic int rand_pct();
    return $unsigned($random(seed)) % 100;
  endfunction

  function automatic fp_word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic fp_format_e pick_fmt(input int idx);
    case (idx)
      0:       return FP16;
      1:       return FP32;
      default: return FP64;
    endcase
  endfunction

  task automatic add_item(input operation_e op, input fp_format_e fmt,
                          input fp_word_t a, input fp_word_t b);
    stim_op.push_back(op);
    stim_fmt.push_back(fmt);
    stim_a.push_back(a);
    stim_b.push_back(b);
  endtask

  task automatic add_random_item(input int dz_pct);
    operation_e op;
    fp_format_e fmt;
    fp_word_t   a;
    fp_word_t   b;
    op  = (rand_pct() < 50) ? DIV : SQRT;
    fmt = pick_fmt(rand_pct() % 3);
    a   = rand_word();
    b   = rand_word() >> (rand_pct() % 64);  // Spread divisor sizes
    if (rand_pct() < dz_pct) b = b & ~width_mask(fmt);  // Zero in width only
    add_item(op, fmt, a, b);
  endtask

  // Per format: plain, exact and zero-divisor divides, squares and non-squares
  task automatic add_directed_items();
    fp_format_e fmt;
    fp_word_t   mask;
    fp_word_t   junk;
    fp_word_t   b;
    fp_word_t   r;
    for (int f = 0; f < 3; f++) begin
      fmt  = pick_fmt(f);
      mask = width_mask(fmt);
      junk = rand_word() & ~mask;            // Upper bits must be ignored
      b    = ((rand_word() & mask) >> 3) | 64'd1;
      r    = rand_word() & (mask >> (fmt_width(fmt) / 2));
      add_item(DIV, fmt, junk | (rand_word() & mask), junk | b);
      add_item(DIV, fmt, junk | (b * 5), b);  // Exact
      add_item(DIV, fmt, rand_word(), junk);  // Zero divisor
      add_item(DIV, fmt, mask, 64'd1);
      add_item(SQRT, fmt, junk | (r * r), rand_word());
      add_item(SQRT, fmt, junk | ((r * r + 64'd2) & mask), '0);
      add_item(SQRT, fmt, mask, '0);
    end
  endtask

  // ---------------------------------------------------------------------
  // Cycle driver and monitor
  // ---------------------------------------------------------------------
  task automatic drive_cycle(input int stall_pct, input int gap_pct);
    @(posedge clk_i);
    if (!in_valid_i || in_taken) begin     // Offered item holds until taken
      if (stim_a.size() != 0 && rand_pct() >= gap_pct) begin
        in_valid_i <= 1'b1;
        operands_i <= {stim_b[0], stim_a[0]};
        op_i       <= stim_op[0];
        dst_fmt_i  <= stim_fmt[0];
        tag_i      <= next_tag;
      end else begin
        in_valid_i <= 1'b0;
      end
    end
    out_ready_i <= (rand_pct() >= stall_pct);
  endtask

  // Mid-cycle sample, handshakes complete at the next rising edge
  task automatic sample_cycle();
    fp_word_t e_res;
    status_t  e_st;
    tag_t     e_tag;
    @(negedge clk_i);
    in_taken = in_valid_i && in_ready_o;
    if (in_taken) begin
      e_res = model_result(op_i, dst_fmt_i, operands_i[0], operands_i[1], e_st);
      exp_res.push_back(e_res);
      exp_st.push_back(e_st);
      exp_tag.push_back(tag_i);
      stim_a.delete(0);
      stim_b.delete(0);
      stim_op.delete(0);
      stim_fmt.delete(0);
      next_tag++;
    end
    if (out_valid_o && out_ready_i) begin
      if (exp_res.size() == 0) begin
        $display("Output with tag %h left with no item outstanding", tag_o);
        other_errs++;
      end else begin
        e_res = exp_res.pop_front();
        e_st  = exp_st.pop_front();
        e_tag = exp_tag.pop_front();
        check_result("result_o", result_o, e_res);
        check_status("status_o", status_o, e_st);
        check_tag("tag_o", tag_o, e_tag);
      end
    end
  endtask

  task automatic run_items(input string phase, input int stall_pct, input int gap_pct,
                           input int max_cycles, input bit drain);
    int cycles;
    bit empty;
    cycles = 0;
    empty  = 1'b0;
    while (!empty && cycles < max_cycles) begin
      drive_cycle(stall_pct, gap_pct);
      sample_cycle();
      cycles++;
      empty = drain && stim_a.size() == 0 && exp_res.size() == 0 && !in_valid_i && !busy_o;
    end
    if (drain && !empty) begin
      $display("Timeout in phase %s with %0d results outstanding", phase, exp_res.size());
      other_errs++;
    end
  endtask

  // One-cycle flush, every item in flight is dropped
  task automatic flush_stream();
    @(posedge clk_i);
    flush_i     <= 1'b1;
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b0;
    @(posedge clk_i);
    flush_i <= 1'b0;
    in_taken = 1'b0;
    stim_a.delete();
    stim_b.delete();
    stim_op.delete();
    stim_fmt.delete();
    exp_res.delete();
    exp_st.delete();
    exp_tag.delete();
    @(negedge clk_i);
    check_level("busy_o", busy_o, 1'b0);
    check_level("out_valid_o", out_valid_o, 1'b0);
  endtask

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin
    int total;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    operands_i  = '0;
    op_i        = DIV;
    dst_fmt_i   = FP64;
    tag_i       = '0;
    out_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_level("in_ready_o", in_ready_o, 1'b0);  // Nothing taken in reset
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_level("out_valid_o", out_valid_o, 1'b0);
    check_level("busy_o", busy_o, 1'b0);
    check_level("in_ready_o", in_ready_o, 1'b1);

    add_directed_items();
    run_items("directed", 0, 0, 4000, 1'b1);

    for (int i = 0; i < 40; i++) add_random_item(10);
    run_items("random stalls", 40, 20, 12000, 1'b1);

    // Back to back, next item starts while the result commits
    for (int i = 0; i < 20; i++) add_random_item(10);
    run_items("back to back", 0, 0, 6000, 1'b1);

    for (int i = 0; i < 16; i++) add_random_item(10);
    run_items("before flush", 30, 0, 150, 1'b0);
    flush_stream();
    run_items("idle after flush", 0, 0, 20, 1'b0);

    for (int i = 0; i < 20; i++) add_random_item(10);
    run_items("after flush", 30, 10, 6000, 1'b1);

    total = value_errs + other_errs + int'(u_dut.u_chk.fail_count);
    $display("Checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             checks, value_errs, other_errs, u_dut.u_chk.fail_count);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
